// ==== Bender.yml ====
package:
  name: sprite_unit

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sprite_pkg.sv
      - verilog/oam_search.sv
      - verilog/sprite_store.sv
      - verilog/sprite_fetch_addr.sv
      - verilog/sprite_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/sprite_unit_checker.sv
      - bench/sprite_unit_tb.sv

// ==== bench/sprite_unit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_unit_checker (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic       pix_valid,
	input  logic       accept,
	input  logic       match_valid,
	input  logic       fetch_valid,
	input  logic [3:0] spr_count
);

	int unsigned fail_count = 0;   // read by the testbench.

	a_fetch_latency: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_valid |-> $past(pix_valid, 2))
		else begin
			fail_count++;
			$error("fetch_valid without a pix_valid two cycles earlier");
		end

	a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
		spr_count <= 4'(`SPR_SLOTS))
		else begin
			fail_count++;
			$error("spr_count above the slot limit");
		end

	// covers every reset cycle and the first cycle after release.
	a_reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !(accept || match_valid || fetch_valid))
		else begin
			fail_count++;
			$error("strobe high around reset");
		end

	a_line_clear: assert property (@(posedge clk) disable iff (!rst_n)
		line_start |=> spr_count == 4'd0)
		else begin
			fail_count++;
			$error("spr_count not cleared by line_start");
		end

endmodule

bind sprite_unit sprite_unit_checker u_checker (
	.clk         (clk),
	.rst_n       (rst_n),
	.line_start  (line_start),
	.pix_valid   (pix_valid),
	.accept      (accept),
	.match_valid (match_valid),
	.fetch_valid (fetch_valid),
	.spr_count   (spr_count)
);

`default_nettype wire

// ==== bench/sprite_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_unit_tb import sprite_pkg::*; ();

	logic clk = 1'b0;
	logic rst_n;
	logic line_start;
	logic [7:0] line;
	logic tall;
	logic oam_valid;
	oam_entry_t oam_entry;
	logic pix_valid;
	logic [7:0] pix_x;
	logic fetch_valid;
	spr_fetch_t fetch;
	logic [3:0] spr_count;

	logic [31:0] lfsr_state = 32'd83688;
	logic [7:0] cur_line;

	// reference model of the line's slots.
	spr_slot_t m_slot [`SPR_SLOTS];
	logic [`SPR_SLOTS-1:0] m_used;
	int model_count;
	logic searching;
	logic [7:0] m_line;
	logic m_tall;
	logic exp_v1;
	logic exp_v2;
	spr_fetch_t exp_f1;
	spr_fetch_t exp_f2;

	sprite_unit u_sprite_unit (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.line        (line),
		.tall        (tall),
		.oam_valid   (oam_valid),
		.oam_entry   (oam_entry),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.fetch_valid (fetch_valid),
		.fetch       (fetch),
		.spr_count   (spr_count)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 32'h80200003;   // x^32 + x^22 + x^2 + x + 1.
		return s;
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	function automatic spr_fetch_t expect_fetch(spr_slot_t s, logic tall_l, int num);
		spr_fetch_t f;
		int h;
		int er;
		int et;
		h = tall_l ? 16 : 8;
		er = s.attr[6] ? h - 1 - int'(s.row) : int'(s.row);
		et = int'(s.tile);
		if (tall_l)
			et = (et & 'hfe) | ((er >> 3) & 1);   // lower tile for rows 8 to 15.
		f.addr = 13'(et * 16 + 2 * (er % 8));
		f.x_flip = s.attr[5];
		f.palette = s.attr[4];
		f.behind_bg = s.attr[7];
		f.idx = s.idx;
		f.num = slot_num_t'(num);
		return f;
	endfunction

	always @(posedge clk) begin
		spr_slot_t s;
		int d;
		int h;
		int hit_slot;
		if (!rst_n) begin
			model_count <= 0;
			searching <= 1'b0;
			m_used <= '0;
			exp_v1 <= 1'b0;
			exp_v2 <= 1'b0;
		end else begin
			exp_v2 <= exp_v1;
			exp_f2 <= exp_f1;
			exp_v1 <= 1'b0;
			h = m_tall ? 16 : 8;
			if (line_start) begin
				m_line <= line;
				m_tall <= tall;
				model_count <= 0;
				searching <= 1'b1;
				m_used <= '0;
			end else begin
				if (oam_valid && searching && model_count < `SPR_SLOTS) begin
					d = int'(m_line) + `SPR_Y_OFS - int'(oam_entry.y);
					if (d >= 0 && d < h) begin
						s.x = oam_entry.x;
						s.tile = oam_entry.tile;
						s.attr = oam_entry.attr;
						s.row = 4'(d);
						s.idx = oam_entry.idx;
						m_slot[model_count] <= s;
						model_count <= model_count + 1;
					end
				end
				if (pix_valid) begin
					hit_slot = -1;
					for (int i = `SPR_SLOTS - 1; i >= 0; i--) begin
						if (i < model_count && !m_used[i] &&
								int'(m_slot[i].x) == int'(pix_x) + `SPR_X_OFS)
							hit_slot = i;
					end
					if (hit_slot >= 0) begin
						m_used[hit_slot] <= 1'b1;
						exp_v1 <= 1'b1;
						exp_f1 <= expect_fetch(m_slot[hit_slot], m_tall, hit_slot);
					end
				end
			end
		end
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	a_fetch_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_valid == exp_v2)
		else report_mismatch("fetch_valid differs from the model");

	a_fetch_value: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_valid |-> fetch == exp_f2)
		else report_mismatch("fetch address or flags differ from the model");

	a_count: assert property (@(posedge clk) disable iff (!rst_n)
		int'(spr_count) == model_count)
		else report_mismatch("spr_count differs from the model");

	always @(posedge clk) begin
		if (u_sprite_unit.u_checker.fail_count != 0) begin
			$display("a protocol assertion in the checker failed");
			$display("Finished with errors");
			$fatal(1);
		end
	end

	task automatic start_line(input logic [7:0] l, input logic t);
		@(posedge clk);
		line_start <= 1'b1;
		line <= l;
		tall <= t;
		cur_line = l;
		@(posedge clk);
		line_start <= 1'b0;
	endtask

	// most entries are placed to cover the current line.
	task automatic send_oam(input int n, input logic force_hit);
		oam_entry_t e;
		logic [7:0] r;
		for (int i = 0; i < n; i++) begin
			take_bits(2, r);
			if (force_hit || r != 8'd0) begin
				take_bits(4, r);
				e.y = cur_line + 8'(`SPR_Y_OFS) - r;
			end else begin
				take_bits(8, r);
				e.y = r;
			end
			take_bits(3, r);
			e.x = 8'd48 + r;   // narrow x range, many shared positions.
			take_bits(8, r);
			e.tile = r;
			take_bits(8, r);
			e.attr = r;
			e.idx = 6'(i);
			@(posedge clk);
			oam_valid <= 1'b1;
			oam_entry <= e;
		end
		@(posedge clk);
		oam_valid <= 1'b0;
	endtask

	task automatic present_pix(input logic [7:0] x, input int reps);
		for (int r = 0; r < reps; r++) begin
			@(posedge clk);
			pix_valid <= 1'b1;
			pix_x <= x;
		end
		@(posedge clk);
		pix_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		int quiet;
		int t;
		quiet = 0;
		t = 0;
		while (quiet < 3) begin
			@(posedge clk);
			if (fetch_valid || exp_v1 || exp_v2 || oam_valid || pix_valid ||
					int'(spr_count) != model_count)
				quiet = 0;
			else
				quiet++;
			t++;
			if (t > 200) begin
				$display("timeout: the sprite pipeline did not go idle");
				$display("Finished with errors");
				$fatal(1);
			end
		end
	endtask

	// each x more often than there are slots, so every match drains.
	task automatic scan_pixels();
		logic [7:0] r;
		for (int x = 40; x < 48; x++)
			present_pix(8'(x), `SPR_SLOTS + 1);
		take_bits(8, r);
		present_pix(r, 1);
		wait_idle();
	endtask

	initial begin
		repeat (50000) @(posedge clk);
		$display("simulation did not finish in time");
		$display("Finished with errors");
		$fatal(1);
	end

	initial begin
		logic [7:0] l;
		logic [7:0] t;
		rst_n = 1'b0;
		line_start = 1'b0;
		line = '0;
		tall = 1'b0;
		oam_valid = 1'b0;
		oam_entry = '0;
		pix_valid = 1'b0;
		pix_x = '0;
		cur_line = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		start_line(8'd50, 1'b0);
		send_oam(20, 1'b0);
		wait_idle();
		scan_pixels();

		start_line(8'd100, 1'b1);   // 14 covering entries, ten kept.
		send_oam(14, 1'b1);
		wait_idle();
		scan_pixels();

		start_line(8'd7, 1'b0);   // old slots must be gone.
		scan_pixels();

		for (int n = 0; n < 6; n++) begin
			take_bits(8, l);
			take_bits(1, t);
			start_line(l, t[0]);
			send_oam(24, 1'b0);
			wait_idle();
			scan_pixels();
		end
		wait_idle();

		if (u_sprite_unit.u_checker.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/sprite_pkg.sv
verilog/oam_search.sv
verilog/sprite_store.sv
verilog/sprite_fetch_addr.sv
verilog/sprite_unit.sv
bench/sprite_unit_checker.sv
bench/sprite_unit_tb.sv

// ==== verilog/oam_search.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module oam_search import sprite_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic [7:0] line,
	input  logic       tall,
	input  logic       oam_valid,
	input  oam_entry_t oam_entry,
	output logic       accept,
	output spr_slot_t  slot,
	output logic [3:0] count,
	output logic       tall_line
);

	search_state_e state;
	logic [7:0] line_q;
	logic [4:0] height;
	logic [8:0] dy;
	logic hit;

	assign height = tall_line ? 5'(2 * `SPR_WIDTH) : 5'(`SPR_WIDTH);

	// line + 16 - y, nine bits so a sprite below the line wraps high.
	assign dy = {1'b0, line_q} + 9'(`SPR_Y_OFS) - {1'b0, oam_entry.y};
	assign hit = dy < {4'b0000, height};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			count <= '0;
			accept <= 1'b0;
			tall_line <= 1'b0;
		end else begin
			accept <= 1'b0;
			if (line_start) begin
				state <= ACTIVE;
				count <= '0;
				tall_line <= tall;   // held for the whole line.
			end else begin
				case (state)
					ACTIVE: begin
						if (oam_valid && hit) begin
							accept <= 1'b1;
							count <= count + 4'd1;
							if (count == 4'(`SPR_SLOTS - 1))
								state <= FULL;   // tenth sprite taken.
						end
					end
					FULL: begin
						state <= FULL;   // rest of the oam is skipped.
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (line_start)
			line_q <= line;
	end

	always_ff @(posedge clk) begin
		if (oam_valid) begin
			slot.x <= oam_entry.x;
			slot.tile <= oam_entry.tile;
			slot.attr <= oam_entry.attr;
			slot.row <= dy[3:0];   // only meaningful on a hit.
			slot.idx <= oam_entry.idx;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_fetch_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_fetch_addr import sprite_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tall,
	input  logic       match_valid,
	input  spr_match_t match,
	output logic       fetch_valid,
	output spr_fetch_t fetch
);

	logic [3:0] row_last;
	logic [3:0] eff_row;
	logic [7:0] eff_tile;
	logic [2:0] tile_row;
	logic [12:0] addr;
	logic y_flip;

	assign y_flip = match.slot.attr[ATTR_Y_FLIP];
	assign row_last = tall ? 4'(2 * `SPR_WIDTH - 1) : 4'(`SPR_WIDTH - 1);
	assign eff_row = y_flip ? (row_last - match.slot.row) : match.slot.row;

	// tall sprites pick the upper or lower tile by row bit 3.
	assign eff_tile = tall ? {match.slot.tile[7:1], eff_row[3]} : match.slot.tile;
	assign tile_row = 3'(eff_row % `SPR_WIDTH);

	// 16 bytes per tile, two bytes per row.
	assign addr = {1'b0, eff_tile, 4'b0000} + 13'({tile_row, 1'b0});

	always_ff @(posedge clk) begin
		if (!rst_n)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= match_valid;
	end

	always_ff @(posedge clk) begin
		if (match_valid) begin
			fetch.addr <= addr;
			fetch.x_flip <= match.slot.attr[ATTR_X_FLIP];
			fetch.palette <= match.slot.attr[ATTR_PAL];
			fetch.behind_bg <= match.slot.attr[ATTR_BG_PRI];
			fetch.idx <= match.slot.idx;
			fetch.num <= match.num;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_params.svh ====
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// sprites kept per scanline.
`define SPR_SLOTS 10

// tiles are square, so this is also the 8x8 height.
`define SPR_WIDTH 8

// oam y of 16 puts the top row on line 0.
`define SPR_Y_OFS 16

// oam x of 8 puts the left column on pixel 0.
`define SPR_X_OFS 8

`endif

// ==== verilog/sprite_pkg.sv ====
`default_nettype none

`include "sprite_params.svh"

package sprite_pkg;

	localparam int SLOT_W = $clog2(`SPR_SLOTS);

	// attribute byte bits.
	localparam int ATTR_BG_PRI = 7;
	localparam int ATTR_Y_FLIP = 6;
	localparam int ATTR_X_FLIP = 5;
	localparam int ATTR_PAL = 4;

	typedef logic [SLOT_W-1:0] slot_num_t;

	typedef struct packed {
		logic [7:0] y;
		logic [7:0] x;
		logic [7:0] tile;
		logic [7:0] attr;
		logic [5:0] idx;     // oam entry number.
	} oam_entry_t;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] tile;
		logic [7:0] attr;
		logic [3:0] row;     // row within sprite, before flip.
		logic [5:0] idx;
	} spr_slot_t;

	typedef struct packed {
		spr_slot_t slot;
		slot_num_t num;
	} spr_match_t;

	typedef struct packed {
		logic [12:0] addr;   // tile data byte address.
		logic        x_flip;
		logic        palette;
		logic        behind_bg;
		logic [5:0]  idx;
		slot_num_t   num;
	} spr_fetch_t;

	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		FULL
	} search_state_e;

endpackage

`default_nettype wire

// ==== verilog/sprite_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sprite_params.svh"

module sprite_store import sprite_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic       accept,
	input  spr_slot_t  slot,
	input  logic       pix_valid,
	input  logic [7:0] pix_x,
	output logic       match_valid,
	output spr_match_t match
);

	spr_slot_t slots [`SPR_SLOTS];
	logic [`SPR_SLOTS-1:0] filled;
	logic [`SPR_SLOTS-1:0] used;
	logic [`SPR_SLOTS-1:0] hit;
	slot_num_t wr_ptr;
	slot_num_t hit_num;
	logic hit_any;
	logic full;
	logic take;
	logic [8:0] want_x;

	assign full = (wr_ptr == slot_num_t'(`SPR_SLOTS));
	assign want_x = {1'b0, pix_x} + 9'(`SPR_X_OFS);   // no wrap past 255.
	assign take = pix_valid && hit_any;

	always_comb begin
		for (int i = 0; i < `SPR_SLOTS; i++)
			hit[i] = filled[i] && !used[i] && ({1'b0, slots[i].x} == want_x);
	end

	// lowest slot wins, so shared x comes out in slot order.
	always_comb begin
		hit_any = 1'b0;
		hit_num = '0;
		for (int i = `SPR_SLOTS - 1; i >= 0; i--) begin
			if (hit[i]) begin
				hit_any = 1'b1;
				hit_num = slot_num_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			match_valid <= 1'b0;
			filled <= '0;
			used <= '0;
			wr_ptr <= '0;
		end else begin
			match_valid <= take;   // in-flight pixels still resolve.
			if (line_start) begin
				filled <= '0;
				used <= '0;
				wr_ptr <= '0;
			end else begin
				if (accept && !full) begin
					filled[wr_ptr] <= 1'b1;
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (take)
					used[hit_num] <= 1'b1;   // next strobe sees the next one.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !full)
			slots[wr_ptr] <= slot;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			match.slot <= slots[hit_num];
			match.num <= hit_num;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sprite_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_unit import sprite_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line_start,
	input  logic [7:0] line,
	input  logic       tall,
	input  logic       oam_valid,
	input  oam_entry_t oam_entry,
	input  logic       pix_valid,
	input  logic [7:0] pix_x,
	output logic       fetch_valid,
	output spr_fetch_t fetch,
	output logic [3:0] spr_count
);

	logic accept;
	spr_slot_t acc_slot;
	logic tall_line;
	logic match_valid;
	spr_match_t match;

	oam_search u_search (
		.clk        (clk),
		.rst_n      (rst_n),
		.line_start (line_start),
		.line       (line),
		.tall       (tall),
		.oam_valid  (oam_valid),
		.oam_entry  (oam_entry),
		.accept     (accept),
		.slot       (acc_slot),
		.count      (spr_count),
		.tall_line  (tall_line)
	);

	sprite_store u_store (
		.clk         (clk),
		.rst_n       (rst_n),
		.line_start  (line_start),
		.accept      (accept),
		.slot        (acc_slot),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.match_valid (match_valid),
		.match       (match)
	);

	sprite_fetch_addr u_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.tall        (tall_line),   // latched per line.
		.match_valid (match_valid),
		.match       (match),
		.fetch_valid (fetch_valid),
		.fetch       (fetch)
	);

endmodule

`default_nettype wire
